//--- src/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry

`define DC_WORD_W      32   // data word
`define DC_TAG_W       26   // tag bits above the index
`define DC_IDX_W       3    // set index
`define DC_SETS        8    // 2**DC_IDX_W
`define DC_BYTE_OFF_W  2    // byte within word
`define DC_WAYS        2    // associativity

`endif

//--- src/dcachePkg.sv
`include "dcache_macros.svh"

package dcachePkg;

   typedef logic [`DC_WORD_W-1:0]   wordT;
   typedef logic [`DC_TAG_W-1:0]    tagT;
   typedef logic [`DC_IDX_W-1:0]    idxT;
   typedef logic [2*`DC_WORD_W-1:0] blockT;    // word 1 in the upper half
   typedef logic [`DC_WORD_W-1:0]   addrT;     // tag, index, word sel, byte off

   typedef struct packed {
      logic read;
      logic write;
      addrT addr;
      wordT storeData;
   } cpuReqT;

   typedef struct packed {
      logic ren;
      logic wen;
      addrT addr;
      wordT storeData;
   } memReqT;

   typedef struct packed {
      logic  isWrite;
      addrT  baseAddr;   // word 0 address
      blockT block;
   } moveCmdT;

   typedef struct packed {
      logic  fillEn;
      logic  wordEn;
      logic  cleanEn;
      idxT   set;
      logic  way;
      logic  wordSel;
      tagT   tag;
      blockT block;
      wordT  word;
   } arrayWrT;

   typedef enum logic [3:0] {
      idle,
      writeBack,
      fill,
      install,
      writeHit,
      flushRead,
      flushMove,
      flushNext,
      flushed
   } ctrlStateT;

endpackage

//--- src/cacheArray.sv
`timescale 1ns/10ps
`include "dcache_macros.svh"

module cacheArray
(
   input  logic               CLK,
   input  logic               nRST,
   input  dcachePkg::addrT    lookupAddr,
   input  dcachePkg::arrayWrT arrayWr,
   input  dcachePkg::idxT     rdSet,
   input  logic               rdWay,
   output logic               hit,
   output logic               hitWay,
   output dcachePkg::wordT    hitWord,
   output logic               victimWay,
   output logic               victimDirty,
   output dcachePkg::tagT     rdTag,
   output dcachePkg::blockT   rdBlock,
   output logic               rdDirty
);

   dcachePkg::tagT   tags [`DC_WAYS][`DC_SETS];
   dcachePkg::blockT data [`DC_WAYS][`DC_SETS];

   logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid;
   logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty;
   logic [`DC_SETS-1:0]               lastFill;   // way filled most recently

   dcachePkg::tagT      lookTag;
   dcachePkg::idxT      lookSet;
   logic                lookWord;
   logic [`DC_WAYS-1:0] wayMatch;
   dcachePkg::blockT    hitBlock;

   assign lookTag  = lookupAddr[`DC_WORD_W-1 -: `DC_TAG_W];
   assign lookSet  = lookupAddr[`DC_BYTE_OFF_W+1 +: `DC_IDX_W];
   assign lookWord = lookupAddr[`DC_BYTE_OFF_W];

   always_comb
   begin
      for (int w = 0; w < `DC_WAYS; w++)
         wayMatch[w] = valid[w][lookSet] && (tags[w][lookSet] == lookTag);
   end

   assign hit      = |wayMatch;
   assign hitWay   = wayMatch[1];
   assign hitBlock = data[hitWay][lookSet];
   assign hitWord  = hitBlock[lookWord*`DC_WORD_W +: `DC_WORD_W];

   // victim is the other way
   assign victimWay   = ~lastFill[lookSet];
   assign victimDirty = dirty[victimWay][lookSet];

   assign rdTag   = tags[rdWay][rdSet];
   assign rdBlock = data[rdWay][rdSet];
   assign rdDirty = dirty[rdWay][rdSet];

   always_ff @(posedge CLK)
   begin
      if (arrayWr.fillEn)
      begin
         tags[arrayWr.way][arrayWr.set] <= arrayWr.tag;
         data[arrayWr.way][arrayWr.set] <= arrayWr.block;
      end
      if (arrayWr.wordEn)
         data[arrayWr.way][arrayWr.set][arrayWr.wordSel*`DC_WORD_W +: `DC_WORD_W] <=
            arrayWr.word;
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         valid    <= '0;
         dirty    <= '0;
         lastFill <= '0;
      end
      else
      begin
         if (arrayWr.fillEn)
         begin
            valid[arrayWr.way][arrayWr.set] <= 1'b1;
            dirty[arrayWr.way][arrayWr.set] <= 1'b0;
            lastFill[arrayWr.set]           <= arrayWr.way;   // flips as fill uses victim
         end
         else if (arrayWr.wordEn)
            dirty[arrayWr.way][arrayWr.set] <= 1'b1;
         else if (arrayWr.cleanEn)
            dirty[arrayWr.way][arrayWr.set] <= 1'b0;   // block now in memory
      end
   end

endmodule

//--- src/cacheController.sv
`timescale 1ns/10ps
`include "dcache_macros.svh"

module cacheController
(
   input  logic               CLK,
   input  logic               nRST,
   input  dcachePkg::cpuReqT  cpuReq,
   input  logic               halt,
   input  logic               hit,
   input  logic               hitWay,
   input  logic               victimWay,
   input  logic               victimDirty,
   input  dcachePkg::tagT     rdTag,
   input  dcachePkg::blockT   rdBlock,
   input  logic               rdDirty,
   input  logic               moveAck,
   input  dcachePkg::blockT   fillBlock,
   output logic               moveReq,
   output dcachePkg::moveCmdT moveCmd,
   output dcachePkg::arrayWrT arrayWr,
   output dcachePkg::idxT     rdSet,
   output logic               rdWay,
   output logic               dhit,
   output logic               flushed
);

   dcachePkg::ctrlStateT state;
   dcachePkg::ctrlStateT nextState;
   dcachePkg::idxT       flushSet;
   logic                 flushWay;
   dcachePkg::tagT       reqTag;
   dcachePkg::idxT       reqSet;
   logic                 pending;
   logic                 inFlush;
   logic                 inMove;
   logic                 moveDone;
   logic                 moveStart;

   assign reqTag    = cpuReq.addr[`DC_WORD_W-1 -: `DC_TAG_W];
   assign reqSet    = cpuReq.addr[`DC_BYTE_OFF_W+1 +: `DC_IDX_W];
   assign pending   = cpuReq.read | cpuReq.write;
   assign inFlush   = state inside {dcachePkg::flushRead, dcachePkg::flushMove,
                                    dcachePkg::flushNext};
   assign inMove    = state inside {dcachePkg::writeBack, dcachePkg::fill,
                                    dcachePkg::flushMove};
   assign moveDone  = moveReq & moveAck;
   assign moveStart = !moveReq & !moveAck;   // last ack has dropped

   always_comb
   begin
      nextState = state;
      case (state)
         dcachePkg::idle:
            if (pending && !hit)
            begin
               if (victimDirty)
                  nextState = dcachePkg::writeBack;
               else
                  nextState = dcachePkg::fill;
            end
            else if (cpuReq.write)
               nextState = dcachePkg::writeHit;
            else if (halt && !pending)
               nextState = dcachePkg::flushRead;
         dcachePkg::writeBack:
            if (moveDone)
               nextState = dcachePkg::fill;
         dcachePkg::fill:
            if (moveDone)
               nextState = dcachePkg::install;
         dcachePkg::install:
            nextState = dcachePkg::idle;   // lookup hits next cycle
         dcachePkg::writeHit:
            nextState = dcachePkg::idle;
         dcachePkg::flushRead:
            if (rdDirty)
               nextState = dcachePkg::flushMove;
            else
               nextState = dcachePkg::flushNext;
         dcachePkg::flushMove:
            if (moveDone)
               nextState = dcachePkg::flushNext;
         dcachePkg::flushNext:
            if ({flushSet, flushWay} == '1)
               nextState = dcachePkg::flushed;
            else
               nextState = dcachePkg::flushRead;
         dcachePkg::flushed:
            nextState = dcachePkg::flushed;   // held until reset
         default:
            nextState = dcachePkg::idle;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state    <= dcachePkg::idle;
         moveReq  <= 1'b0;
         flushSet <= '0;
         flushWay <= 1'b0;
      end
      else
      begin
         state <= nextState;
         if (inMove)
         begin
            if (moveDone)
               moveReq <= 1'b0;
            else if (moveStart)
               moveReq <= 1'b1;
         end
         if (state == dcachePkg::idle)
            {flushSet, flushWay} <= '0;
         else if (state == dcachePkg::flushNext)
            {flushSet, flushWay} <= {flushSet, flushWay} + 1'b1;   // way first, then set
      end
   end

   assign rdSet = inFlush ? flushSet : reqSet;
   assign rdWay = inFlush ? flushWay : victimWay;

   always_comb
   begin
      moveCmd.isWrite = (state != dcachePkg::fill);
      moveCmd.block   = rdBlock;
      if (state == dcachePkg::fill)
         moveCmd.baseAddr = {reqTag, reqSet, {(`DC_BYTE_OFF_W+1){1'b0}}};
      else
         moveCmd.baseAddr = {rdTag, rdSet, {(`DC_BYTE_OFF_W+1){1'b0}}};
   end

   always_comb
   begin
      arrayWr.set     = rdSet;
      arrayWr.way     = (state == dcachePkg::writeHit) ? hitWay : rdWay;
      arrayWr.wordSel = cpuReq.addr[`DC_BYTE_OFF_W];
      arrayWr.tag     = reqTag;
      arrayWr.block   = fillBlock;
      arrayWr.word    = cpuReq.storeData;
      arrayWr.fillEn  = (state == dcachePkg::install);
      arrayWr.wordEn  = (state == dcachePkg::writeHit);
      arrayWr.cleanEn = moveDone && (state inside {dcachePkg::writeBack, dcachePkg::flushMove});
   end

   assign dhit    = (state == dcachePkg::idle && cpuReq.read && hit) ||
                    (state == dcachePkg::writeHit);
   assign flushed = (state == dcachePkg::flushed);

endmodule

//--- src/blockMover.sv
`timescale 1ns/10ps
`include "dcache_macros.svh"

module blockMover
(
   input  logic               CLK,
   input  logic               nRST,
   input  logic               moveReq,
   input  dcachePkg::moveCmdT moveCmd,
   input  logic               dwait,
   input  dcachePkg::wordT    dload,
   output logic               moveAck,
   output dcachePkg::blockT   fillBlock,
   output dcachePkg::memReqT  memReq
);

   logic active;     // block transfer on the memory port
   logic wordCnt;    // word of the block in flight
   logic wordDone;

   assign wordDone = active & !dwait;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         active  <= 1'b0;
         wordCnt <= 1'b0;
         moveAck <= 1'b0;
      end
      else
      begin
         if (!active && !moveAck && moveReq)
         begin
            active  <= 1'b1;
            wordCnt <= 1'b0;
         end
         else if (wordDone)
         begin
            wordCnt <= ~wordCnt;
            if (wordCnt)
            begin
               active  <= 1'b0;
               moveAck <= 1'b1;   // both words done
            end
         end
         else if (moveAck && !moveReq)
            moveAck <= 1'b0;
      end
   end

   // read words held from ack until the next read move
   always_ff @(posedge CLK)
   begin
      if (wordDone && !moveCmd.isWrite)
         fillBlock[wordCnt*`DC_WORD_W +: `DC_WORD_W] <= dload;
   end

   always_comb
   begin
      memReq.ren       = active & !moveCmd.isWrite;
      memReq.wen       = active & moveCmd.isWrite;
      memReq.addr      = '0;
      memReq.storeData = '0;
      if (active)
      begin
         memReq.addr      = {moveCmd.baseAddr[`DC_WORD_W-1:`DC_BYTE_OFF_W+1], wordCnt,
                             {`DC_BYTE_OFF_W{1'b0}}};
         memReq.storeData = moveCmd.block[wordCnt*`DC_WORD_W +: `DC_WORD_W];
      end
   end

endmodule

//--- src/dcacheTop.sv
`timescale 1ns/10ps

module dcacheTop
(
   input  logic              CLK,
   input  logic              nRST,
   input  dcachePkg::cpuReqT cpuReq,
   input  logic              halt,
   output logic              dhit,
   output dcachePkg::wordT   dmemload,
   output logic              flushed,
   output dcachePkg::memReqT memReq,
   input  logic              dwait,
   input  dcachePkg::wordT   dload
);

   // lookup results
   logic               hit;
   logic               hitWay;
   logic               victimWay;
   logic               victimDirty;
   dcachePkg::tagT     rdTag;
   dcachePkg::blockT   rdBlock;
   logic               rdDirty;

   // controller to array
   dcachePkg::arrayWrT arrayWr;
   dcachePkg::idxT     rdSet;
   logic               rdWay;

   // controller to mover
   logic               moveReq;
   logic               moveAck;
   dcachePkg::moveCmdT moveCmd;
   dcachePkg::blockT   fillBlock;

   cacheArray cacheArrayInst
   (
      .CLK         (CLK),
      .nRST        (nRST),
      .lookupAddr  (cpuReq.addr),
      .arrayWr     (arrayWr),
      .rdSet       (rdSet),
      .rdWay       (rdWay),
      .hit         (hit),
      .hitWay      (hitWay),
      .hitWord     (dmemload),
      .victimWay   (victimWay),
      .victimDirty (victimDirty),
      .rdTag       (rdTag),
      .rdBlock     (rdBlock),
      .rdDirty     (rdDirty)
   );

   cacheController cacheControllerInst
   (
      .CLK         (CLK),
      .nRST        (nRST),
      .cpuReq      (cpuReq),
      .halt        (halt),
      .hit         (hit),
      .hitWay      (hitWay),
      .victimWay   (victimWay),
      .victimDirty (victimDirty),
      .rdTag       (rdTag),
      .rdBlock     (rdBlock),
      .rdDirty     (rdDirty),
      .moveAck     (moveAck),
      .fillBlock   (fillBlock),
      .moveReq     (moveReq),
      .moveCmd     (moveCmd),
      .arrayWr     (arrayWr),
      .rdSet       (rdSet),
      .rdWay       (rdWay),
      .dhit        (dhit),
      .flushed     (flushed)
   );

   blockMover blockMoverInst
   (
      .CLK       (CLK),
      .nRST      (nRST),
      .moveReq   (moveReq),
      .moveCmd   (moveCmd),
      .dwait     (dwait),
      .dload     (dload),
      .moveAck   (moveAck),
      .fillBlock (fillBlock),
      .memReq    (memReq)
   );

endmodule

//--- test/clockGen.sv
`timescale 1ns/10ps

module clockGen
(
   output logic CLK,
   output logic nRST
);

   localparam int resetCycles = 16;

   initial
   begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;   // 20 ns period
   end

   initial
   begin
      nRST = 1'b0;
      repeat (resetCycles) @(posedge CLK);
      nRST <= 1'b1;
   end

endmodule

//--- test/memModel.sv
`timescale 1ns/10ps
`include "dcache_macros.svh"

module memModel
(
   input  logic              CLK,
   input  logic              nRST,
   input  dcachePkg::memReqT memReq,
   output logic              dwait,
   output dcachePkg::wordT   dload,
   input  dcachePkg::addrT   peekAddr,
   output dcachePkg::wordT   peekData,
   output logic [31:0]       readCount
);

   localparam int          memWords = 1024;          // first 4 KB are backed
   localparam logic [31:0] fillMask = 32'hA5A5A5A5;
   localparam logic [31:0] lfsrSeed = 32'h25dd5e2f;
   localparam logic [31:0] lfsrTaps = 32'h80200003;

   dcachePkg::wordT mem [memWords];
   logic [31:0]     lfsr;
   logic [1:0]      nextWait;   // drawn ahead for the next word
   logic [1:0]      waitLeft;
   logic            busy;
   logic [1:0]      curWait;
   logic            reqOn;

   // two LFSR steps, one per bit of the wait count
   function automatic logic [33:0] drawWait(input logic [31:0] s);
      logic [1:0] w;
      for (int b = 0; b < 2; b++)
      begin
         w[b] = s[0];
         s    = (s >> 1) ^ (s[0] ? lfsrTaps : 32'h0);
      end
      return {s, w};
   endfunction

   assign reqOn   = memReq.ren | memReq.wen;
   assign curWait = busy ? waitLeft : nextWait;
   assign dwait   = reqOn && (curWait != 2'd0);

   // outside the backed range the initial pattern is returned
   assign dload    = (memReq.addr[31:12] == '0) ? mem[memReq.addr[11:2]] :
                                                  (memReq.addr ^ fillMask);
   assign peekData = (peekAddr[31:12] == '0) ? mem[peekAddr[11:2]] : (peekAddr ^ fillMask);

   always @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         for (int i = 0; i < memWords; i++)
            mem[i] <= (32'(i) << 2) ^ fillMask;
         {lfsr, nextWait} <= drawWait(lfsrSeed);
         waitLeft  <= 2'd0;
         busy      <= 1'b0;
         readCount <= '0;
      end
      else if (reqOn)
      begin
         if (curWait == 2'd0)
         begin
            if (memReq.wen && memReq.addr[31:12] == '0)
               mem[memReq.addr[11:2]] <= memReq.storeData;
            if (memReq.ren && memReq.addr[`DC_BYTE_OFF_W])
               readCount <= readCount + 1;   // word 1 ends a block read
            busy             <= 1'b0;
            {lfsr, nextWait} <= drawWait(lfsr);
         end
         else
         begin
            busy     <= 1'b1;
            waitLeft <= curWait - 2'd1;
         end
      end
   end

endmodule

//--- test/dcache_checker.sv
`timescale 1ns/10ps

module dcacheChecker
(
   input logic              CLK,
   input logic              nRST,
   input dcachePkg::memReqT memReq,
   input logic              dwait,
   input logic              flushed,
   input logic              moveReq,
   input logic              moveAck
);

   int failCount = 0;   // failed assertion count

   memEnablesExclusive : assert property (
      @(posedge CLK) disable iff (!nRST) !(memReq.ren && memReq.wen))
   else
   begin
      failCount++;
      $error("memory ren and wen both high");
   end

   memReqHeld : assert property (
      @(posedge CLK) disable iff (!nRST)
      ((memReq.ren || memReq.wen) && dwait) |=> $stable(memReq))
   else
   begin
      failCount++;
      $error("memory request changed while dwait was high");
   end

   flushedSticky : assert property (
      @(posedge CLK) disable iff (!nRST) flushed |=> flushed)
   else
   begin
      failCount++;
      $error("flushed fell before reset");
   end

   ackNeedsReq : assert property (
      @(posedge CLK) disable iff (!nRST) $rose(moveAck) |-> moveReq)
   else
   begin
      failCount++;
      $error("moveAck rose without moveReq");
   end

endmodule

bind dcacheTop dcacheChecker checkerInst
(
   .CLK     (CLK),
   .nRST    (nRST),
   .memReq  (memReq),
   .dwait   (dwait),
   .flushed (flushed),
   .moveReq (moveReq),
   .moveAck (moveAck)
);

//--- test/dcacheTb.sv
`timescale 1ns/10ps
`include "dcache_macros.svh"

module dcacheTb;

   typedef struct packed {
      logic [1:0]      op;
      dcachePkg::addrT addr;
      dcachePkg::wordT data;
      dcachePkg::wordT expData;
      logic [1:0]      expReads;   // block reads the row should cause
   } rowT;

   localparam logic [1:0] opRead  = 2'd0;
   localparam logic [1:0] opWrite = 2'd1;
   localparam logic [1:0] opMem   = 2'd2;   // look into the memory model
   localparam logic [1:0] opHalt  = 2'd3;
   localparam int         accessLimit = 400;
   localparam int         flushLimit  = 4000;

   logic              CLK;
   logic              nRST;
   dcachePkg::cpuReqT cpuReq;
   logic              halt;
   logic              dhit;
   dcachePkg::wordT   dmemload;
   logic              flushed;
   dcachePkg::memReqT memReq;
   logic              dwait;
   dcachePkg::wordT   dload;
   dcachePkg::addrT   peekAddr;
   dcachePkg::wordT   peekData;
   logic [31:0]       readCount;

   rowT  rows[$];
   int   passed;
   int   failed;
   logic rowOk;
   logic aborted;

   clockGen clockGenInst (.CLK(CLK), .nRST(nRST));

   memModel memModelInst
   (
      .CLK       (CLK),
      .nRST      (nRST),
      .memReq    (memReq),
      .dwait     (dwait),
      .dload     (dload),
      .peekAddr  (peekAddr),
      .peekData  (peekData),
      .readCount (readCount)
   );

   dcacheTop dcacheTop_inst
   (
      .CLK      (CLK),
      .nRST     (nRST),
      .cpuReq   (cpuReq),
      .halt     (halt),
      .dhit     (dhit),
      .dmemload (dmemload),
      .flushed  (flushed),
      .memReq   (memReq),
      .dwait    (dwait),
      .dload    (dload)
   );

   function automatic dcachePkg::addrT blockAddr(input int tag, input int set, input int word);
      return {tag[`DC_TAG_W-1:0], set[`DC_IDX_W-1:0], word[0], {`DC_BYTE_OFF_W{1'b0}}};
   endfunction

   // memory content before any write
   function automatic dcachePkg::wordT initAt(input int tag, input int set, input int word);
      return blockAddr(tag, set, word) ^ 32'hA5A5A5A5;
   endfunction

   function automatic string opName(input logic [1:0] op);
      case (op)
         opRead:  return "read ";
         opWrite: return "write";
         opMem:   return "mem  ";
         default: return "halt ";
      endcase
   endfunction

   task automatic addRow(input logic [1:0] op, input int tag, input int set, input int word,
                         input dcachePkg::wordT data, input dcachePkg::wordT expData,
                         input logic [1:0] expReads);
      rows.push_back({op, blockAddr(tag, set, word), data, expData, expReads});
   endtask

   task automatic buildTable();
      addRow(opRead, 1, 0, 0, '0, initAt(1, 0, 0), 1);   // cold miss
      addRow(opRead, 1, 0, 0, '0, initAt(1, 0, 0), 0);
      addRow(opRead, 1, 0, 1, '0, initAt(1, 0, 1), 0);
      addRow(opWrite, 2, 1, 0, 32'h1111_0210, '0, 1);   // write miss fills first
      addRow(opRead, 2, 1, 0, '0, 32'h1111_0210, 0);
      addRow(opRead, 2, 1, 1, '0, initAt(2, 1, 1), 0);
      // tag 3 takes the way of tag 1 in set 2
      addRow(opRead, 1, 2, 0, '0, initAt(1, 2, 0), 1);
      addRow(opRead, 2, 2, 0, '0, initAt(2, 2, 0), 1);
      addRow(opRead, 3, 2, 1, '0, initAt(3, 2, 1), 1);
      addRow(opRead, 2, 2, 1, '0, initAt(2, 2, 1), 0);
      addRow(opRead, 1, 2, 0, '0, initAt(1, 2, 0), 1);
      addRow(opWrite, 1, 3, 0, 32'h3333_0130, '0, 1);
      addRow(opRead, 2, 3, 0, '0, initAt(2, 3, 0), 1);
      addRow(opRead, 3, 3, 0, '0, initAt(3, 3, 0), 1);   // evicts dirty tag 1
      addRow(opMem, 1, 3, 0, '0, 32'h3333_0130, 0);
      addRow(opMem, 1, 3, 1, '0, initAt(1, 3, 1), 0);
      addRow(opRead, 1, 3, 0, '0, 32'h3333_0130, 1);
      addRow(opWrite, 4, 4, 0, 32'h4444_0440, '0, 1);
      addRow(opWrite, 4, 4, 1, 32'h4444_0441, '0, 0);   // plain write hit
      addRow(opWrite, 5, 4, 1, 32'h4444_0541, '0, 1);
      addRow(opWrite, 7, 4, 0, 32'h4444_0740, '0, 1);   // write miss with dirty victim
      addRow(opWrite, 4, 5, 1, 32'h5555_0451, '0, 1);
      addRow(opWrite, 5, 5, 0, 32'h5555_0550, '0, 1);
      addRow(opWrite, 6, 6, 0, 32'h6666_0660, '0, 1);
      addRow(opMem, 5, 5, 0, '0, initAt(5, 5, 0), 0);   // still only in the cache
      addRow(opHalt, 0, 0, 0, '0, '0, 0);
      addRow(opMem, 4, 4, 0, '0, 32'h4444_0440, 0);
      addRow(opMem, 4, 4, 1, '0, 32'h4444_0441, 0);
      addRow(opMem, 5, 4, 1, '0, 32'h4444_0541, 0);
      addRow(opMem, 5, 4, 0, '0, initAt(5, 4, 0), 0);
      addRow(opMem, 7, 4, 0, '0, 32'h4444_0740, 0);
      addRow(opMem, 4, 5, 1, '0, 32'h5555_0451, 0);
      addRow(opMem, 5, 5, 0, '0, 32'h5555_0550, 0);
      addRow(opMem, 6, 6, 0, '0, 32'h6666_0660, 0);
      addRow(opMem, 2, 1, 0, '0, 32'h1111_0210, 0);
      addRow(opMem, 2, 1, 1, '0, initAt(2, 1, 1), 0);
   endtask

   // called just after a rising edge
   task automatic accessCache(input rowT r);
      int waitCnt;
      cpuReq.read      <= (r.op == opRead);
      cpuReq.write     <= (r.op == opWrite);
      cpuReq.addr      <= r.addr;
      cpuReq.storeData <= r.data;
      waitCnt = 0;
      @(negedge CLK);
      while (!dhit && waitCnt < accessLimit)
      begin
         @(negedge CLK);
         waitCnt++;
      end
      if (!dhit)
      begin
         $display("no dhit within %0d cycles for address %h", accessLimit, r.addr);
         rowOk   = 1'b0;
         aborted = 1'b1;
      end
      else if (r.op == opRead && dmemload !== r.expData)
      begin
         $display("Mismatch dmemload: got %h expected %h", dmemload, r.expData);
         rowOk = 1'b0;
      end
      @(posedge CLK);
      cpuReq <= '0;
   endtask

   task automatic checkMemWord(input rowT r);
      peekAddr <= r.addr;
      @(negedge CLK);
      if (peekData !== r.expData)
      begin
         $display("Mismatch peekData at %h: got %h expected %h", r.addr, peekData, r.expData);
         rowOk = 1'b0;
      end
   endtask

   task automatic flushCache();
      int waitCnt;
      halt    <= 1'b1;
      waitCnt = 0;
      @(negedge CLK);
      while (!flushed && waitCnt < flushLimit)
      begin
         @(negedge CLK);
         waitCnt++;
      end
      if (!flushed)
      begin
         $display("flushed did not rise within %0d cycles", flushLimit);
         rowOk   = 1'b0;
         aborted = 1'b1;
      end
      else
      begin
         for (int c = 0; c < 20; c++)
         begin
            @(negedge CLK);
            if (!flushed && rowOk)
            begin
               $display("flushed fell again after it had risen");
               rowOk = 1'b0;
            end
         end
      end
   endtask

   initial
   begin
      rowT         r;
      int          waitCnt;
      logic [31:0] startReads;
      cpuReq   = '0;
      halt     = 1'b0;
      peekAddr = '0;
      passed   = 0;
      failed   = 0;
      aborted  = 1'b0;
      buildTable();
      waitCnt = 0;
      while (!nRST && waitCnt < 100)
      begin
         @(negedge CLK);
         waitCnt++;
      end
      if (!nRST)
      begin
         $display("reset was never released");
         aborted = 1'b1;
      end
      for (int i = 0; i < rows.size() && !aborted; i++)
      begin
         r     = rows[i];
         rowOk = 1'b1;
         @(negedge CLK);
         startReads = readCount;
         @(posedge CLK);
         case (r.op)
            opMem:   checkMemWord(r);
            opHalt:  flushCache();
            default: accessCache(r);
         endcase
         @(negedge CLK);
         if (readCount - startReads != 32'(r.expReads))
         begin
            $display("Mismatch readCount: got %h new block reads expected %h",
                     readCount - startReads, 32'(r.expReads));
            rowOk = 1'b0;
         end
         if (rowOk)
            passed++;
         else
            failed++;
         $display("row %0d %s %h: %s", i, opName(r.op), r.addr, rowOk ? "ok" : "FAIL");
      end
      $display("%0d rows run, %0d passed, %0d failed, %0d assertion failures",
               passed + failed, passed, failed, dcacheTop_inst.checkerInst.failCount);
      if (failed == 0 && !aborted && dcacheTop_inst.checkerInst.failCount == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

//--- files.f
+incdir+src
src/dcachePkg.sv
src/cacheArray.sv
src/cacheController.sv
src/blockMover.sv
src/dcacheTop.sv
test/clockGen.sv
test/memModel.sv
test/dcache_checker.sv
test/dcacheTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module dcacheTb \
   -Mdir obj_dir -o simv

out=$(./obj_dir/simv +verilator+error+limit+1000) || true
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
   exit 0
fi
exit 1
